// ==== hdl/mips_ex_pkg.sv ====
`default_nettype none

package mips_ex_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] imm_t;       // Extended upstream in ID
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_ctrl_t;

    // Main opcode classes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_SLTIU = 6'b001011;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;

    // R-type function codes
    localparam funct_t F_SLL  = 6'b000000;
    localparam funct_t F_SRL  = 6'b000010;
    localparam funct_t F_SRA  = 6'b000011;
    localparam funct_t F_SLLV = 6'b000100;
    localparam funct_t F_SRLV = 6'b000110;
    localparam funct_t F_SRAV = 6'b000111;
    localparam funct_t F_JALR = 6'b001001;
    localparam funct_t F_ADD  = 6'b100000;
    localparam funct_t F_ADDU = 6'b100001;
    localparam funct_t F_SUB  = 6'b100010;
    localparam funct_t F_SUBU = 6'b100011;
    localparam funct_t F_AND  = 6'b100100;
    localparam funct_t F_OR   = 6'b100101;
    localparam funct_t F_XOR  = 6'b100110;
    localparam funct_t F_NOR  = 6'b100111;
    localparam funct_t F_SLT  = 6'b101010;
    localparam funct_t F_SLTU = 6'b101011;

    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_AND  = 4'd2;
    localparam alu_ctrl_t ALU_OR   = 4'd3;
    localparam alu_ctrl_t ALU_XOR  = 4'd4;
    localparam alu_ctrl_t ALU_NOR  = 4'd5;
    localparam alu_ctrl_t ALU_SLT  = 4'd6;
    localparam alu_ctrl_t ALU_SLTU = 4'd7;
    localparam alu_ctrl_t ALU_SLL  = 4'd8;
    localparam alu_ctrl_t ALU_SRL  = 4'd9;
    localparam alu_ctrl_t ALU_SRA  = 4'd10;
    localparam alu_ctrl_t ALU_LUI  = 4'd11;

    localparam reg_addr_t LINK_REG = 5'd31;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
        logic byte_en;
        logic halfword_en;
        logic word_en;
    } mem_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    typedef struct packed {
        wb_ctrl_t  wb;
        mem_ctrl_t mem;
        logic      alu_src;
        logic      reg_dest;
        opcode_t   alu_op;
        pc_t       pc;
        data_t     data_a;
        data_t     data_b;
        imm_t      immediate;
        data_t     shamt;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        wb_ctrl_t  wb;
        mem_ctrl_t mem;
        pc_t       branch_addr;
        logic      zero;
        data_t     alu_result;
        data_t     data_a;        // Store data
        reg_addr_t dest_reg;
        logic      link;
        pc_t       pc;
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== hdl/alu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_control (
    input  wire logic                   i_clock,
    input  wire mips_ex_pkg::opcode_t   i_alu_op,
    input  wire mips_ex_pkg::funct_t    i_funct_code,
    input  wire logic                   i_reg_write,
    output mips_ex_pkg::alu_ctrl_t      o_alu_ctrl,
    output logic                        o_shamt_sel,
    output logic                        o_link
);

    import mips_ex_pkg::*;

    logic op_known;

    always_comb begin
        o_alu_ctrl  = ALU_ADD;
        o_shamt_sel = 1'b0;
        o_link      = 1'b0;
        op_known    = 1'b1;
        case (i_alu_op)
            OP_ADDI, OP_ADDIU, OP_LW, OP_SW: o_alu_ctrl = ALU_ADD;
            OP_JAL: begin
                o_alu_ctrl = ALU_ADD;
                o_link     = 1'b1;
            end
            OP_BEQ, OP_BNE: o_alu_ctrl = ALU_SUB;   // Compare by subtraction
            OP_ANDI:        o_alu_ctrl = ALU_AND;
            OP_ORI:         o_alu_ctrl = ALU_OR;
            OP_XORI:        o_alu_ctrl = ALU_XOR;
            OP_SLTI:        o_alu_ctrl = ALU_SLT;
            OP_SLTIU:       o_alu_ctrl = ALU_SLTU;
            OP_LUI:         o_alu_ctrl = ALU_LUI;
            OP_RTYPE: begin
                case (i_funct_code)
                    F_ADD, F_ADDU: o_alu_ctrl = ALU_ADD;
                    F_SUB, F_SUBU: o_alu_ctrl = ALU_SUB;
                    F_AND:         o_alu_ctrl = ALU_AND;
                    F_OR:          o_alu_ctrl = ALU_OR;
                    F_XOR:         o_alu_ctrl = ALU_XOR;
                    F_NOR:         o_alu_ctrl = ALU_NOR;
                    F_SLT:         o_alu_ctrl = ALU_SLT;
                    F_SLTU:        o_alu_ctrl = ALU_SLTU;
                    F_SLLV:        o_alu_ctrl = ALU_SLL;
                    F_SRLV:        o_alu_ctrl = ALU_SRL;
                    F_SRAV:        o_alu_ctrl = ALU_SRA;
                    F_SLL: begin
                        o_alu_ctrl  = ALU_SLL;
                        o_shamt_sel = 1'b1;
                    end
                    F_SRL: begin
                        o_alu_ctrl  = ALU_SRL;
                        o_shamt_sel = 1'b1;
                    end
                    F_SRA: begin
                        o_alu_ctrl  = ALU_SRA;
                        o_shamt_sel = 1'b1;
                    end
                    F_JALR: begin
                        o_alu_ctrl = ALU_ADD;
                        o_link     = 1'b1;   // Return address goes to r31
                    end
                    default: op_known = 1'b0;
                endcase
            end
            default: op_known = 1'b0;
        endcase
    end

    // A register write must come from a decodable instruction
    a_known_op: assert property (@(posedge i_clock) i_reg_write |-> op_known)
        else $error("alu_control: unknown op %h funct %h", i_alu_op, i_funct_code);

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire mips_ex_pkg::data_t     i_a,
    input  wire mips_ex_pkg::data_t     i_b,
    input  wire mips_ex_pkg::alu_ctrl_t i_alu_ctrl,
    output mips_ex_pkg::data_t          o_result,
    output logic                        o_zero
);

    import mips_ex_pkg::*;

    logic [4:0] sh_amt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign sh_amt      = i_a[4:0];   // Only the low five bits shift
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_alu_ctrl)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_NOR:  o_result = ~(i_a | i_b);
            ALU_SLT:  o_result = data_t'(lt_signed);
            ALU_SLTU: o_result = data_t'(lt_unsigned);
            ALU_SLL:  o_result = i_b << sh_amt;
            ALU_SRL:  o_result = i_b >> sh_amt;
            ALU_SRA:  o_result = data_t'($signed(i_b) >>> sh_amt);   // Sign fill
            ALU_LUI:  o_result = {i_b[15:0], 16'h0000};
            default:  o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire logic                i_clock,
    input  wire mips_ex_pkg::id_ex_t i_id_ex,
    output mips_ex_pkg::ex_mem_t     o_ex_mem
);

    import mips_ex_pkg::*;

    funct_t    funct_code;
    alu_ctrl_t alu_ctrl;
    logic      shamt_sel;
    logic      link;
    data_t     alu_data_a;
    data_t     alu_data_b;
    data_t     alu_result;
    logic      zero;
    reg_addr_t rt_rd;
    reg_addr_t dest_reg;
    pc_t       branch_addr;

    assign funct_code = i_id_ex.immediate[5:0];   // Funct sits in the low imm bits

    alu_control u_alu_control (
        .i_clock      (i_clock),
        .i_alu_op     (i_id_ex.alu_op),
        .i_funct_code (funct_code),
        .i_reg_write  (i_id_ex.wb.reg_write),
        .o_alu_ctrl   (alu_ctrl),
        .o_shamt_sel  (shamt_sel),
        .o_link       (link)
    );

    assign alu_data_a = shamt_sel ? i_id_ex.shamt : i_id_ex.data_a;
    assign alu_data_b = i_id_ex.alu_src ? data_t'(i_id_ex.immediate) : i_id_ex.data_b;

    alu u_alu (
        .i_a        (alu_data_a),
        .i_b        (alu_data_b),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (zero)
    );

    // Destination: rt or rd, overridden by the link register
    assign rt_rd    = i_id_ex.reg_dest ? i_id_ex.rd : i_id_ex.rt;
    assign dest_reg = link ? LINK_REG : rt_rd;

    // Word offset to byte offset
    assign branch_addr = i_id_ex.pc + pc_t'(i_id_ex.immediate << 2);

    always_comb begin
        o_ex_mem             = '0;
        o_ex_mem.wb          = i_id_ex.wb;
        o_ex_mem.mem         = i_id_ex.mem;
        o_ex_mem.branch_addr = branch_addr;
        o_ex_mem.zero        = zero;
        o_ex_mem.alu_result  = alu_result;
        o_ex_mem.data_a      = i_id_ex.data_a;
        o_ex_mem.dest_reg    = dest_reg;
        o_ex_mem.link        = link;
        o_ex_mem.pc          = i_id_ex.pc;
    end

endmodule

`default_nettype wire

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  wire logic                i_clock,
    input  wire logic                i_arst_n,
    input  wire logic                i_flush,
    input  wire mips_ex_pkg::id_ex_t i_id_ex,
    output mips_ex_pkg::id_ex_t      o_id_ex
);

    import mips_ex_pkg::*;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;
        end else if (i_flush) begin
            o_id_ex <= '0;   // Bubble, all controls inactive
        end else begin
            o_id_ex <= i_id_ex;
        end
    end

    // A stage never reads and writes memory in the same instruction
    a_no_rw: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        !(o_id_ex.mem.mem_read && o_id_ex.mem.mem_write)
    ) else $error("id_ex_reg: mem_read and mem_write both set");

endmodule

`default_nettype wire

// ==== hdl/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  wire logic                 i_clock,
    input  wire logic                 i_arst_n,
    input  wire mips_ex_pkg::ex_mem_t i_ex_mem,
    output mips_ex_pkg::ex_mem_t      o_ex_mem
);

    import mips_ex_pkg::*;

    logic mem_access;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem <= i_ex_mem;
        end
    end

    assign mem_access = o_ex_mem.mem.mem_read | o_ex_mem.mem.mem_write;

    // Access width must be unambiguous
    a_one_width: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        mem_access |-> $onehot0({o_ex_mem.mem.byte_en,
                                 o_ex_mem.mem.halfword_en,
                                 o_ex_mem.mem.word_en})
    ) else $error("ex_mem_reg: more than one access width set");

endmodule

`default_nettype wire

// ==== hdl/ex_pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipeline_top (
    input  wire logic                i_clock,
    input  wire logic                i_arst_n,
    input  wire logic                i_flush,
    input  wire mips_ex_pkg::id_ex_t i_id_ex,
    output mips_ex_pkg::ex_mem_t     o_ex_mem
);

    import mips_ex_pkg::*;

    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;

    id_ex_reg u_id_ex_reg (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_id_ex  (i_id_ex),
        .o_id_ex  (id_ex_q)
    );

    ex_stage u_ex_stage (
        .i_clock  (i_clock),
        .i_id_ex  (id_ex_q),
        .o_ex_mem (ex_mem_d)
    );

    ex_mem_reg u_ex_mem_reg (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_ex_mem (ex_mem_d),
        .o_ex_mem (o_ex_mem)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_ex_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_pipeline;

    import mips_ex_pkg::*;

    localparam int MAX_CASES    = 32;
    localparam int WORDS        = 10;    // 32-bit words per case line
    localparam int DEPTH        = 512;
    localparam int RESET_CYCLES = 5;
    localparam int LATENCY      = 2;
    localparam int MARGIN       = 20;

    logic    clock = 1'b0;
    logic    arst_n;
    logic    flush;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    logic [31:0] case_words [0:DEPTH-1];
    int          n_cases;
    int          pass_count   = 0;
    int          fail_count   = 0;
    int          check_errors = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 1000;
    int          step;

    always #2 clock = ~clock;   // 4 ns period

    ex_pipeline_top u_ex_pipeline_top (
        .i_clock  (clock),
        .i_arst_n (arst_n),
        .i_flush  (flush),
        .i_id_ex  (id_ex),
        .o_ex_mem (ex_mem)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] word_at(input int k, input int w);
        logic [8:0] addr;
        addr = 9'(k * WORDS + w);
        return case_words[addr];
    endfunction

    // Control word digits are flush, wb, mem(2), alu_src, reg_dest, alu_op(2)
    function automatic id_ex_t stimulus_of(input int k);
        id_ex_t      s;
        logic [31:0] c;
        logic [31:0] r;
        c           = word_at(k, 0);
        r           = word_at(k, 6);
        s           = '0;
        s.wb        = c[25:24];
        s.mem       = c[21:16];
        s.alu_src   = c[12];
        s.reg_dest  = c[8];
        s.alu_op    = c[5:0];
        s.pc        = word_at(k, 1);
        s.data_a    = word_at(k, 2);
        s.data_b    = word_at(k, 3);
        s.immediate = word_at(k, 4);
        s.shamt     = word_at(k, 5);
        s.rt        = r[12:8];
        s.rd        = r[4:0];
        return s;
    endfunction

    task automatic load_cases();
        logic [31:0] c;
        for (int a = 0; a < DEPTH; a++) begin
            case_words[9'(a)] = '0;
        end
        $readmemh("testbench/ex_cases.mem", case_words);
        n_cases = 0;
        c = word_at(0, 0);
        while (n_cases < MAX_CASES && c != '0) begin
            n_cases++;
            c = word_at(n_cases, 0);
        end
    endtask

    task automatic drive_case(input int k);
        logic [31:0] c;
        c     = word_at(k, 0);
        flush = c[28];
        id_ex = stimulus_of(k);
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h got %h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic verify_reset();
        assert (ex_mem === '0) else begin
            $display("MISMATCH o_ex_mem expected %h got %h", ex_mem_t'(0), ex_mem);
            check_errors++;
        end
        if (check_errors == 0) pass_count++;
        else fail_count++;
        $display("reset: %s", (check_errors == 0) ? "pass" : "fail");
        check_errors = 0;
    endtask

    // Flags word digits are zero, link, wb, mem(2), 0, dest(2)
    task automatic verify_case(input int k);
        logic [31:0] f;
        logic [31:0] c;
        id_ex_t      s;
        c = word_at(k, 0);
        f = word_at(k, 9);
        s = stimulus_of(k);
        check_errors = 0;
        compare_field("alu_result", word_at(k, 7), ex_mem.alu_result);
        compare_field("branch_addr", word_at(k, 8), ex_mem.branch_addr);
        compare_field("zero", 32'(f[28]), 32'(ex_mem.zero));
        compare_field("link", 32'(f[24]), 32'(ex_mem.link));
        compare_field("wb", 32'(f[21:20]), 32'(ex_mem.wb));
        compare_field("mem", 32'(f[17:12]), 32'(ex_mem.mem));
        compare_field("dest_reg", 32'(f[4:0]), 32'(ex_mem.dest_reg));
        compare_field("pc", c[28] ? 32'h0 : s.pc, ex_mem.pc);   // Bubble clears pc
        compare_field("data_a", c[28] ? 32'h0 : s.data_a, ex_mem.data_a);
        if (check_errors == 0) pass_count++;
        else fail_count++;
        $display("case %0d op %h flush %0d: %s", k, s.alu_op, c[28],
                 (check_errors == 0) ? "pass" : "fail");
    endtask

    initial begin
        arst_n = 1'b0;
        flush  = 1'b0;
        id_ex  = '0;
        load_cases();
        cycle_limit = n_cases + RESET_CYCLES + LATENCY + MARGIN;
        if (n_cases == 0) begin
            $display("No test cases were found in the case file");
            fail_count++;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        verify_reset();
        if (n_cases > 0) drive_case(0);
        // Each record is checked two cycles after it is driven
        for (step = 1; step < n_cases + LATENCY; step++) begin
            @(negedge clock);
            if (step >= LATENCY) verify_case(step - LATENCY);
            if (step < n_cases) begin
                drive_case(step);
            end else begin
                flush = 1'b0;
                id_ex = '0;
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/ex_cases.mem ====
// ctrl(flush wb mem2 alu_src reg_dest op2) pc data_a data_b imm shamt regs(rt2 rd2)
// then expected: alu_result branch_addr flags(zero link wb mem2 0 dest2)
02000100 00000100 00000005 00000007 00000020 00000000 00000203 0000000c 00000180 00200003 // add
02000100 00000104 12345678 12345678 00000022 00000000 00000204 00000000 0000018c 10200004 // sub
02000100 00000108 f0f0f0f0 ff00ff00 00000024 00000000 00000205 f000f000 00000198 00200005 // and
02000100 0000010c f0f0f0f0 0f000f00 00000025 00000000 00000206 fff0fff0 000001a0 00200006 // or
02000100 00000110 aaaa5555 ffff0000 00000026 00000000 00000207 55555555 000001a8 00200007 // xor
02000100 00000114 0000ffff 00ff0000 00000027 00000000 00000208 ff000000 000001b0 00200008 // nor
02000100 00000118 fffffffe 00000001 0000002a 00000000 00000209 00000001 000001c0 00200009 // slt
02000100 0000011c fffffffe 00000001 0000002b 00000000 0000020a 00000000 000001c8 1020000a // sltu
12000100 00000120 11111111 22222222 00000020 00000000 0000020b 00000000 00000000 10000000 // flush
02001008 00000124 00000010 deadbeef fffffff0 00000000 00000c1d 00000000 000000e4 1020000c // addi
0200100c 00000128 12345678 00000000 0000ff0f 00000000 00000d1e 00005608 0003fd64 0020000d // andi
0200100d 0000012c 12340000 00000000 00005678 00000000 00000e1f 12345678 00015b0c 0020000e // ori
0200100f 00000130 00000000 00000000 0000abcd 00000000 00000f10 abcd0000 0002b064 0020000f // lui
03211023 00000134 10000000 00000000 00000010 00000000 00001000 10000010 00000174 00321010 // lw
0014102b 00000138 10000000 000000aa fffffffc 00000000 00001100 0ffffffc 00000128 00014011 // sw
02000100 0000013c ffffffff 00000003 00000000 00000004 00000212 00000030 0000013c 00200012 // sll
02000100 00000140 00000000 80000000 00000002 00000008 00000213 00800000 00000148 00200013 // srl
02000100 00000144 00000000 80000000 00000003 00000004 00000214 f8000000 00000150 00200014 // sra
02000100 00000148 00000024 0000000f 00000004 0000001f 00000215 000000f0 00000158 00200015 // sllv
02000100 0000014c 00000010 ff000000 00000006 00000001 00000216 0000ff00 00000164 00200016 // srlv
02000100 00000150 0000001c 90000000 00000007 00000001 00000217 fffffff9 0000016c 00200017 // srav
00080004 00000200 00000042 00000042 fffffffe 00000000 00001800 00000000 000001f8 10008018 // beq
00080005 00000204 00000005 00000003 00000010 00000000 00001900 00000002 00000244 00008019 // bne
02000003 00400020 00000000 00000000 00000001 00000000 00000506 00000000 00400024 1120001f // jal
02000100 00400100 00001000 00000004 00000009 00000000 00000708 00001004 00400124 0120001f // jalr

// ==== build.f ====
hdl/mips_ex_pkg.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/ex_stage.sv
hdl/id_ex_reg.sv
hdl/ex_mem_reg.sv
hdl/ex_pipeline_top.sv
testbench/tb_ex_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute-slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ex_pipeline -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ex_pipeline)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1
